// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= video_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: sources.f
verilog/video_pkg.sv
verilog/wb_addr_decoder.sv
verilog/gpio_regs.sv
verilog/vsync_generator.sv
verilog/bg_pixel_source.sv
verilog/pixel_fifo.sv
verilog/vout_axi4s.sv
verilog/video_top.sv
verification/video_checker.sv
verification/video_tb.sv

// File: verification/video_checker.sv
`timescale 1ns/100ps
`default_nettype none

module video_checker import video_pkg::*; #(
	parameter int X_NUM     = 16,
	parameter int Y_NUM     = 4,
	parameter int HSYNC_LEN = 2,
	parameter int V_TOTAL   = 7,
	parameter int LED_WIDTH = 4
) (
	input  wire logic                 core_clk,
	input  wire logic                 rst_i,

	// bus and pins under observation
	input  wire wb_req_t              req_i,
	input  wire wb_rsp_t              rsp_i,
	input  wire logic [LED_WIDTH-1:0] led_i,
	input  wire video_sync_t          sync_i,
	input  wire rgb_t                 data_i,

	// expectations from the testbench
	input  wire logic                 rd_chk_i,
	input  wire logic [31:0]          rd_exp_i,
	input  wire logic                 led_chk_i,
	input  wire logic [LED_WIDTH-1:0] led_exp_i,
	input  wire logic                 arm_i,
	input  wire logic                 mode_i,
	input  wire rgb_t                 color_i,

	output logic                      frame_done_o,
	output logic                      mismatch_o,
	output logic [31:0]               exp_o,
	output logic [31:0]               act_o,
	output int                        timing_errs_o
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WAIT  = 2'd1;
	localparam logic [1:0] ST_CHECK = 2'd2;

	video_sync_t prev_q;
	logic        synced_q;
	logic        vs_rise;
	int          de_run;
	int          hs_run;
	int          hs_pulses;
	int          de_lines;
	logic [1:0]  fstate;
	int          vs_cnt;
	int          pix_cnt;
	logic        exp_mode;
	rgb_t        exp_color;

	assign vs_rise = sync_i.vsync && !prev_q.vsync;

	// background pattern for one output position
	function automatic rgb_t expected_pixel(input logic mode, input rgb_t color,
		input int x, input int y);
		rgb_t px;
		if (mode) begin
			px = color;
		end else begin
			px.r = x[7:0];
			px.g = y[7:0];
			px.b = color.b;
		end
		return px;
	endfunction

	always_ff @(posedge core_clk) begin : seq_check
		int   errs;
		rgb_t exp_px;
		errs = 0;
		exp_px = '0;
		if (rst_i) begin
			prev_q        <= '0;
			synced_q      <= 1'b0;
			de_run        <= 0;
			hs_run        <= 0;
			hs_pulses     <= 0;
			de_lines      <= 0;
			fstate        <= ST_IDLE;
			vs_cnt        <= 0;
			pix_cnt       <= 0;
			exp_mode      <= 1'b0;
			exp_color     <= '0;
			frame_done_o  <= 1'b0;
			mismatch_o    <= 1'b0;
			exp_o         <= '0;
			act_o         <= '0;
			timing_errs_o <= 0;
		end else begin
			prev_q     <= sync_i;
			mismatch_o <= 1'b0;

			// ------------------------------
			// register bus and pins
			// ------------------------------
			if (rd_chk_i && req_i.stb && !req_i.we && rsp_i.ack && rsp_i.dat != rd_exp_i) begin
				mismatch_o <= 1'b1;
				exp_o      <= rd_exp_i;
				act_o      <= rsp_i.dat;
			end
			if (led_chk_i && led_i != led_exp_i) begin
				mismatch_o <= 1'b1;
				exp_o      <= 32'(led_exp_i);
				act_o      <= 32'(led_i);
			end

			// ------------------------------
			// sync timing
			// ------------------------------
			if (sync_i.de) begin
				de_run <= de_run + 1;
			end else if (prev_q.de) begin
				if (synced_q && de_run != X_NUM) begin
					$display("line %0d had %0d display cycles instead of %0d",
						de_lines, de_run, X_NUM);
					errs++;
				end
				de_run   <= 0;
				de_lines <= de_lines + 1;
			end

			if (sync_i.hsync) begin
				hs_run <= hs_run + 1;
			end else if (prev_q.hsync) begin
				if (synced_q && hs_run != HSYNC_LEN) begin
					$display("hsync pulse lasted %0d cycles instead of %0d", hs_run, HSYNC_LEN);
					errs++;
				end
				hs_run    <= 0;
				hs_pulses <= hs_pulses + 1;
			end

			if (vs_rise) begin
				if (synced_q && de_lines != Y_NUM) begin
					$display("frame had %0d display lines instead of %0d", de_lines, Y_NUM);
					errs++;
				end
				// one hsync pulse per line
				if (synced_q && hs_pulses != V_TOTAL) begin
					$display("frame had %0d hsync pulses instead of %0d", hs_pulses, V_TOTAL);
					errs++;
				end
				de_lines  <= 0;
				hs_pulses <= 0;
				synced_q  <= 1'b1;
			end

			// ------------------------------
			// armed frame check
			// ------------------------------
			if (fstate == ST_CHECK && sync_i.de) begin
				exp_px = expected_pixel(exp_mode, exp_color, de_run, de_lines);
				pix_cnt <= pix_cnt + 1;
				if (data_i != exp_px) begin
					mismatch_o <= 1'b1;
					exp_o      <= {8'h00, exp_px};
					act_o      <= {8'h00, data_i};
				end
			end

			if (arm_i) begin
				fstate       <= ST_WAIT;
				vs_cnt       <= 0;
				exp_mode     <= mode_i;
				exp_color    <= color_i;
				frame_done_o <= 1'b0;
			end else if (vs_rise) begin
				if (fstate == ST_WAIT) begin
					// skip the first full frame, alignment may still settle
					if (vs_cnt == 1) begin
						fstate  <= ST_CHECK;
						pix_cnt <= 0;
					end else begin
						vs_cnt <= vs_cnt + 1;
					end
				end else if (fstate == ST_CHECK) begin
					if (pix_cnt != X_NUM * Y_NUM) begin
						$display("checked frame had %0d pixels instead of %0d",
							pix_cnt, X_NUM * Y_NUM);
						errs++;
					end
					fstate       <= ST_IDLE;
					frame_done_o <= 1'b1;
				end
			end

			timing_errs_o <= timing_errs_o + errs;
		end
	end

endmodule

`default_nettype wire

// File: verification/video_tb.sv
`timescale 1ns/100ps
`default_nettype none

module video_tb import video_pkg::*; ();

	localparam int X_NUM       = 16;
	localparam int Y_NUM       = 4;
	localparam int HTOTAL      = 24;
	localparam int HSYNC_START = 18;
	localparam int HSYNC_END   = 20;
	localparam int VTOTAL      = 7;
	localparam int VSYNC_START = 5;
	localparam int VSYNC_END   = 6;
	localparam int LED_W       = 4;
	localparam int CLK_NS      = 10;

	localparam rgb_t INIT_COLOR = 24'h204060;

	logic        core_clk;
	logic        rst_i;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [3:0]  led;
	video_sync_t vout_sync;
	rgb_t        vout_data;

	// checker control and results
	logic        rd_chk;
	logic [31:0] rd_exp;
	logic        led_chk;
	logic [3:0]  led_exp;
	logic        arm;
	logic        arm_mode;
	rgb_t        arm_color;
	logic        frame_done;
	logic        mismatch;
	logic [31:0] exp_val;
	logic [31:0] act_val;
	int          timing_errs;

	// access table
	string       t_name[$];
	logic [15:0] t_adr[$];
	logic        t_we[$];
	logic [31:0] t_dat[$];
	logic [31:0] t_exp[$];
	logic [3:0]  t_led[$];
	logic        t_frame[$];

	string       cur_name;
	int          value_errs;
	integer      seed;
	longint      wd_ns;
	logic        table_ready;
	logic        bg_mode;
	rgb_t        bg_color;

	video_top #(
		.VOUT_X_NUM       (X_NUM),
		.VOUT_Y_NUM       (Y_NUM),
		.INIT_HTOTAL      (HTOTAL),
		.INIT_HSYNC_START (HSYNC_START),
		.INIT_HSYNC_END   (HSYNC_END),
		.INIT_VTOTAL      (VTOTAL),
		.INIT_VSYNC_START (VSYNC_START),
		.INIT_VSYNC_END   (VSYNC_END),
		.GPIO_WIDTH       (LED_W),
		.GPIO_INIT_OUT    (4'b0101),
		.FIFO_PTR_WIDTH   (3),
		.INIT_BG_COLOR    (INIT_COLOR)
	) u_dut (
		.core_clk    (core_clk),
		.rst_i       (rst_i),
		.wb_req_i    (wb_req),
		.wb_rsp_o    (wb_rsp),
		.led_o       (led),
		.vout_sync_o (vout_sync),
		.vout_data_o (vout_data)
	);

	video_checker #(
		.X_NUM     (X_NUM),
		.Y_NUM     (Y_NUM),
		.HSYNC_LEN (HSYNC_END - HSYNC_START),
		.V_TOTAL   (VTOTAL),
		.LED_WIDTH (LED_W)
	) u_checker (
		.core_clk      (core_clk),
		.rst_i         (rst_i),
		.req_i         (wb_req),
		.rsp_i         (wb_rsp),
		.led_i         (led),
		.sync_i        (vout_sync),
		.data_i        (vout_data),
		.rd_chk_i      (rd_chk),
		.rd_exp_i      (rd_exp),
		.led_chk_i     (led_chk),
		.led_exp_i     (led_exp),
		.arm_i         (arm),
		.mode_i        (arm_mode),
		.color_i       (arm_color),
		.frame_done_o  (frame_done),
		.mismatch_o    (mismatch),
		.exp_o         (exp_val),
		.act_o         (act_val),
		.timing_errs_o (timing_errs)
	);

	initial begin
		core_clk = 1'b0;
		forever #(CLK_NS / 2) core_clk = ~core_clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic add_entry(input string name, input logic [15:0] adr, input logic we,
		input logic [31:0] dat, input logic [31:0] exp, input logic [3:0] led_val,
		input logic frame);
		t_name.push_back(name);
		t_adr.push_back(adr);
		t_we.push_back(we);
		t_dat.push_back(dat);
		t_exp.push_back(exp);
		t_led.push_back(led_val);
		t_frame.push_back(frame);
	endtask

	// one bus cycle, then a look at the LED pins
	task automatic run_access(input int idx);
		@(negedge core_clk);
		wb_req.adr = t_adr[idx];
		wb_req.dat = t_dat[idx];
		wb_req.we  = t_we[idx];
		wb_req.sel = 4'hf;
		wb_req.stb = 1'b1;
		rd_chk     = !t_we[idx];
		rd_exp     = t_exp[idx];
		@(posedge core_clk);
		// every region answers in the strobe cycle
		if (!wb_rsp.ack) begin
			$display("%s: no ack in the cycle of the strobe", t_name[idx]);
			value_errs++;
		end
		while (!wb_rsp.ack) begin
			@(posedge core_clk);
		end
		@(negedge core_clk);
		wb_req.stb = 1'b0;
		rd_chk     = 1'b0;
		led_chk    = 1'b1;
		led_exp    = t_led[idx];
		@(negedge core_clk);
		led_chk = 1'b0;
		// track what the pixel source now holds
		if (t_we[idx] && t_adr[idx][15:8] == REGION_BGSRC) begin
			if (t_adr[idx][7:0] == BGSRC_MODE) begin
				bg_mode = t_dat[idx][0];
			end else if (t_adr[idx][7:0] == BGSRC_COLOR) begin
				bg_color = rgb_t'(t_dat[idx][23:0]);
			end
		end
	endtask

	task automatic check_frame();
		@(negedge core_clk);
		arm       = 1'b1;
		arm_mode  = bg_mode;
		arm_color = bg_color;
		@(negedge core_clk);
		arm = 1'b0;
		while (!frame_done) begin
			@(negedge core_clk);
		end
	endtask

	always @(negedge core_clk) begin
		if (mismatch) begin
			$display("[ERROR] %s: expected %h, actual %h", cur_name, exp_val, act_val);
			value_errs++;
		end
	end

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin
		wait (table_ready);
		#(wd_ns);
		$display("watchdog timeout after %0d ns, the tests did not finish", wd_ns);
		$display("*** FAILED ***");
		$finish;
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main
		int   errs_before;
		int   errs_now;
		int   total;
		rgb_t color1;
		rgb_t color2;

		seed        = 32'he270e860;
		rst_i       = 1'b1;
		wb_req      = '0;
		rd_chk      = 1'b0;
		rd_exp      = '0;
		led_chk     = 1'b0;
		led_exp     = '0;
		arm         = 1'b0;
		arm_mode    = 1'b0;
		arm_color   = '0;
		value_errs  = 0;
		table_ready = 1'b0;
		cur_name    = "reset";
		bg_mode     = 1'b1;
		bg_color    = INIT_COLOR;

		color1 = rgb_t'($random(seed));
		color2 = rgb_t'($random(seed));

		// name, address, write, data, expected read, expected LEDs, frame check
		add_entry("gid_read", 16'h0000, 1'b0, 32'h0, 32'h01234567, 4'b0101, 1'b0);
		add_entry("unmapped_read", 16'h0400, 1'b0, 32'h0, 32'h0, 4'b0101, 1'b0);
		add_entry("gpio_out_reset", 16'h0301, 1'b0, 32'h0, 32'h5, 4'b0101, 1'b0);
		add_entry("gpio_out_write", 16'h0301, 1'b1, 32'ha, 32'h0, 4'b1010, 1'b0);
		add_entry("gpio_out_readback", 16'h0301, 1'b0, 32'h0, 32'ha, 4'b1010, 1'b0);
		add_entry("gpio_dir_clear", 16'h0300, 1'b1, 32'hd, 32'h0, 4'b1000, 1'b0);
		add_entry("gpio_dir_readback", 16'h0300, 1'b0, 32'h0, 32'hd, 4'b1000, 1'b0);
		add_entry("vsgen_htotal_read", 16'h0201, 1'b0, 32'h0, 32'(HTOTAL), 4'b1000, 1'b0);
		add_entry("vsgen_ctl_read", 16'h0200, 1'b0, 32'h0, 32'h1, 4'b1000, 1'b0);
		add_entry("bg_color_write", 16'h0101, 1'b1, {8'h00, color1}, 32'h0, 4'b1000, 1'b0);
		add_entry("bg_color_readback", 16'h0101, 1'b0, 32'h0, {8'h00, color1}, 4'b1000, 1'b0);
		add_entry("bg_mode1_frame", 16'h0100, 1'b1, 32'h1, 32'h0, 4'b1000, 1'b1);
		add_entry("bg_color2_write", 16'h0101, 1'b1, {8'h00, color2}, 32'h0, 4'b1000, 1'b0);
		add_entry("bg_mode0_frame", 16'h0100, 1'b1, 32'h0, 32'h0, 4'b1000, 1'b1);
		add_entry("bg_mode_readback", 16'h0100, 1'b0, 32'h0, 32'h0, 4'b1000, 1'b0);

		wd_ns = longint'(t_name.size() + 6) * HTOTAL * VTOTAL * CLK_NS;
		table_ready = 1'b1;

		repeat (4) @(posedge core_clk);
		@(negedge core_clk);
		rst_i = 1'b0;

		for (int i = 0; i < t_name.size(); i++) begin
			cur_name    = t_name[i];
			errs_before = value_errs + timing_errs;
			run_access(i);
			if (t_frame[i]) begin
				check_frame();
			end
			@(posedge core_clk);
			errs_now = value_errs + timing_errs - errs_before;
			if (errs_now == 0) begin
				$display("test %0d %s: ok", i, t_name[i]);
			end else begin
				$display("test %0d %s: %0d error(s)", i, t_name[i], errs_now);
			end
		end

		total = value_errs + timing_errs;
		$display("tests %0d, value errors %0d, timing errors %0d",
			t_name.size(), value_errs, timing_errs);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/bg_pixel_source.sv
`timescale 1ns/100ps
`default_nettype none

module bg_pixel_source import video_pkg::*; #(
	parameter int   VOUT_X_NUM    = 1280,
	parameter int   VOUT_Y_NUM    = 720,
	parameter rgb_t INIT_BG_COLOR = 24'h0000ff
) (
	input  wire logic    core_clk,
	input  wire logic    rst_i,

	input  wire wb_req_t wb_req_i,
	input  wire logic    stb_i,
	output wb_rsp_t      wb_rsp_o,

	output pix_stream_t  m_data_o,
	output logic         m_valid_o,
	input  wire logic    m_ready_i
);

	logic                    mode_q;
	rgb_t                    color_q;
	logic [TIMING_WIDTH-1:0] x_q;
	logic [TIMING_WIDTH-1:0] y_q;
	pix_stream_t             next_item;

	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			mode_q  <= 1'b1;
			color_q <= INIT_BG_COLOR;
		end else if (stb_i && wb_req_i.we) begin
			case (wb_req_i.adr[7:0])
				BGSRC_MODE:  mode_q  <= wb_req_i.sel[0] ? wb_req_i.dat[0] : mode_q;
				BGSRC_COLOR: color_q <= rgb_t'(wb_merge(WB_DAT_WIDTH'(color_q),
					wb_req_i.dat, wb_req_i.sel));
				default: ;
			endcase
		end
	end

	assign wb_rsp_o.ack = stb_i;
	assign wb_rsp_o.dat = (wb_req_i.adr[7:0] == BGSRC_MODE)  ? WB_DAT_WIDTH'(mode_q) :
	                      (wb_req_i.adr[7:0] == BGSRC_COLOR) ? WB_DAT_WIDTH'(color_q) : '0;

	// pixel at the current x/y position
	always_comb begin
		next_item.tuser = (x_q == '0) && (y_q == '0);
		next_item.tlast = (x_q == TIMING_WIDTH'(VOUT_X_NUM - 1));
		if (mode_q) begin
			next_item.data = color_q;
		end else begin
			next_item.data = '{r: x_q[7:0], g: y_q[7:0], b: color_q.b};
		end
	end

	// output register, reloads only when empty or taken
	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			m_valid_o <= 1'b0;
			x_q       <= '0;
			y_q       <= '0;
		end else if (!m_valid_o || m_ready_i) begin
			m_valid_o <= 1'b1;
			if (next_item.tlast) begin
				x_q <= '0;
				y_q <= (y_q == TIMING_WIDTH'(VOUT_Y_NUM - 1)) ? '0 : y_q + 1'b1;
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	always_ff @(posedge core_clk) begin
		if (!m_valid_o || m_ready_i) begin
			m_data_o <= next_item;
		end
	end

endmodule

`default_nettype wire

// File: verilog/gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_regs import video_pkg::*; #(
	parameter int                    GPIO_WIDTH    = 4,
	parameter logic [GPIO_WIDTH-1:0] GPIO_INIT_OUT = '0
) (
	input  wire logic                   core_clk,
	input  wire logic                   rst_i,

	input  wire wb_req_t                wb_req_i,
	input  wire logic                   stb_i,
	output wb_rsp_t                     wb_rsp_o,

	output logic       [GPIO_WIDTH-1:0] led_o
);

	logic [GPIO_WIDTH-1:0] dir_q;
	logic [GPIO_WIDTH-1:0] out_q;

	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			dir_q <= '1;
			out_q <= GPIO_INIT_OUT;
		end else if (stb_i && wb_req_i.we) begin
			case (wb_req_i.adr[7:0])
				GPIO_DIR: dir_q <= GPIO_WIDTH'(wb_merge(WB_DAT_WIDTH'(dir_q),
					wb_req_i.dat, wb_req_i.sel));
				GPIO_OUT: out_q <= GPIO_WIDTH'(wb_merge(WB_DAT_WIDTH'(out_q),
					wb_req_i.dat, wb_req_i.sel));
				default: ;
			endcase
		end
	end

	always_comb begin
		wb_rsp_o.ack = stb_i;
		case (wb_req_i.adr[7:0])
			GPIO_DIR: wb_rsp_o.dat = WB_DAT_WIDTH'(dir_q);
			GPIO_OUT: wb_rsp_o.dat = WB_DAT_WIDTH'(out_q);
			default:  wb_rsp_o.dat = '0;
		endcase
	end

	// input pins read as 0
	assign led_o = out_q & dir_q;

endmodule

`default_nettype wire

// File: verilog/pixel_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_fifo import video_pkg::*; #(
	parameter int PTR_WIDTH = 6
) (
	input  wire logic        core_clk,
	input  wire logic        rst_i,

	input  wire pix_stream_t s_data_i,
	input  wire logic        s_valid_i,
	output logic             s_ready_o,

	output pix_stream_t      m_data_o,
	output logic             m_valid_o,
	input  wire logic        m_ready_i
);

	localparam int DEPTH = 1 << PTR_WIDTH;

	pix_stream_t          mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH:0]   count;
	logic                 full;
	logic                 push;
	logic                 pop;

	assign full      = (count == (PTR_WIDTH+1)'(DEPTH));
	assign s_ready_o = !full;
	assign m_valid_o = (count != '0);
	assign push      = s_valid_i && s_ready_o;
	assign pop       = m_valid_o && m_ready_i;

	always_ff @(posedge core_clk) begin
		if (push) begin
			mem[wr_ptr] <= s_data_i;
		end
	end

	// first word falls through from the head
	assign m_data_o = mem[rd_ptr];

	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// an overflowing push would carry the count past the depth
	a_no_overflow: assert property (@(posedge core_clk) disable iff (rst_i)
		count <= (PTR_WIDTH+1)'(DEPTH));

endmodule

`default_nettype wire

// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

	// ------------------------------
	// host bus
	// ------------------------------
	localparam int WB_ADR_WIDTH = 16;
	localparam int WB_DAT_WIDTH = 32;
	localparam int WB_SEL_WIDTH = 4;

	// upper address byte selects the region
	localparam logic [7:0] REGION_GID   = 8'h00;
	localparam logic [7:0] REGION_BGSRC = 8'h01;
	localparam logic [7:0] REGION_VSGEN = 8'h02;
	localparam logic [7:0] REGION_GPIO  = 8'h03;

	localparam logic [WB_DAT_WIDTH-1:0] GLOBAL_ID = 32'h01234567;

	// register offsets in the low address byte
	localparam logic [7:0] VSGEN_CTL         = 8'd0;
	localparam logic [7:0] VSGEN_HTOTAL      = 8'd1;
	localparam logic [7:0] VSGEN_HDISP_END   = 8'd2;
	localparam logic [7:0] VSGEN_HSYNC_START = 8'd3;
	localparam logic [7:0] VSGEN_HSYNC_END   = 8'd4;
	localparam logic [7:0] VSGEN_VTOTAL      = 8'd5;
	localparam logic [7:0] VSGEN_VDISP_END   = 8'd6;
	localparam logic [7:0] VSGEN_VSYNC_START = 8'd7;
	localparam logic [7:0] VSGEN_VSYNC_END   = 8'd8;

	localparam logic [7:0] GPIO_DIR = 8'd0;
	localparam logic [7:0] GPIO_OUT = 8'd1;

	localparam logic [7:0] BGSRC_MODE  = 8'd0;
	localparam logic [7:0] BGSRC_COLOR = 8'd1;

	localparam int TIMING_WIDTH = 12;

	// ------------------------------
	// bundles
	// ------------------------------
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		logic tuser;
		logic tlast;
		rgb_t data;
	} pix_stream_t;

	typedef struct packed {
		logic vsync;
		logic hsync;
		logic de;
	} video_sync_t;

	typedef struct packed {
		logic [WB_ADR_WIDTH-1:0] adr;
		logic [WB_DAT_WIDTH-1:0] dat;
		logic                    we;
		logic [WB_SEL_WIDTH-1:0] sel;
		logic                    stb;
	} wb_req_t;

	typedef struct packed {
		logic [WB_DAT_WIDTH-1:0] dat;
		logic                    ack;
	} wb_rsp_t;

	// register write under byte selects
	function automatic logic [WB_DAT_WIDTH-1:0] wb_merge(
		input logic [WB_DAT_WIDTH-1:0] cur,
		input logic [WB_DAT_WIDTH-1:0] dat,
		input logic [WB_SEL_WIDTH-1:0] sel
	);
		logic [WB_DAT_WIDTH-1:0] res;
		res = cur;
		for (int i = 0; i < WB_SEL_WIDTH; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = dat[i*8 +: 8];
			end
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// File: verilog/video_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_top import video_pkg::*; #(
	parameter int                    VOUT_X_NUM       = 1280,
	parameter int                    VOUT_Y_NUM       = 720,
	parameter int                    INIT_HTOTAL      = 1650,
	parameter int                    INIT_HSYNC_START = 1390,
	parameter int                    INIT_HSYNC_END   = 1430,
	parameter int                    INIT_VTOTAL      = 750,
	parameter int                    INIT_VSYNC_START = 725,
	parameter int                    INIT_VSYNC_END   = 730,
	parameter int                    GPIO_WIDTH       = 4,
	parameter logic [GPIO_WIDTH-1:0] GPIO_INIT_OUT    = 4'b0101,
	parameter int                    FIFO_PTR_WIDTH   = 6,
	parameter rgb_t                  INIT_BG_COLOR    = 24'h0000ff
) (
	input  wire logic                   core_clk,
	input  wire logic                   rst_i,

	input  wire wb_req_t                wb_req_i,
	output wb_rsp_t                     wb_rsp_o,

	output logic       [GPIO_WIDTH-1:0] led_o,

	output video_sync_t                 vout_sync_o,
	output rgb_t                        vout_data_o
);

	// ------------------------------
	// register bus
	// ------------------------------
	logic    bgsrc_stb;
	logic    vsgen_stb;
	logic    gpio_stb;
	wb_rsp_t bgsrc_rsp;
	wb_rsp_t vsgen_rsp;
	wb_rsp_t gpio_rsp;

	wb_addr_decoder u_decoder (
		.wb_req_i    (wb_req_i),
		.bgsrc_stb_o (bgsrc_stb),
		.vsgen_stb_o (vsgen_stb),
		.gpio_stb_o  (gpio_stb),
		.bgsrc_rsp_i (bgsrc_rsp),
		.vsgen_rsp_i (vsgen_rsp),
		.gpio_rsp_i  (gpio_rsp),
		.wb_rsp_o    (wb_rsp_o)
	);

	gpio_regs #(
		.GPIO_WIDTH    (GPIO_WIDTH),
		.GPIO_INIT_OUT (GPIO_INIT_OUT)
	) u_gpio (
		.core_clk (core_clk),
		.rst_i    (rst_i),
		.wb_req_i (wb_req_i),
		.stb_i    (gpio_stb),
		.wb_rsp_o (gpio_rsp),
		.led_o    (led_o)
	);

	// ------------------------------
	// video path
	// ------------------------------
	pix_stream_t src_data;
	logic        src_valid;
	logic        src_ready;
	pix_stream_t fifo_data;
	logic        fifo_valid;
	logic        fifo_ready;
	video_sync_t vsgen_sync;

	bg_pixel_source #(
		.VOUT_X_NUM    (VOUT_X_NUM),
		.VOUT_Y_NUM    (VOUT_Y_NUM),
		.INIT_BG_COLOR (INIT_BG_COLOR)
	) u_bgsrc (
		.core_clk  (core_clk),
		.rst_i     (rst_i),
		.wb_req_i  (wb_req_i),
		.stb_i     (bgsrc_stb),
		.wb_rsp_o  (bgsrc_rsp),
		.m_data_o  (src_data),
		.m_valid_o (src_valid),
		.m_ready_i (src_ready)
	);

	pixel_fifo #(
		.PTR_WIDTH (FIFO_PTR_WIDTH)
	) u_fifo (
		.core_clk  (core_clk),
		.rst_i     (rst_i),
		.s_data_i  (src_data),
		.s_valid_i (src_valid),
		.s_ready_o (src_ready),
		.m_data_o  (fifo_data),
		.m_valid_o (fifo_valid),
		.m_ready_i (fifo_ready)
	);

	vsync_generator #(
		.VOUT_X_NUM       (VOUT_X_NUM),
		.VOUT_Y_NUM       (VOUT_Y_NUM),
		.INIT_HTOTAL      (INIT_HTOTAL),
		.INIT_HSYNC_START (INIT_HSYNC_START),
		.INIT_HSYNC_END   (INIT_HSYNC_END),
		.INIT_VTOTAL      (INIT_VTOTAL),
		.INIT_VSYNC_START (INIT_VSYNC_START),
		.INIT_VSYNC_END   (INIT_VSYNC_END)
	) u_vsgen (
		.core_clk (core_clk),
		.rst_i    (rst_i),
		.wb_req_i (wb_req_i),
		.stb_i    (vsgen_stb),
		.wb_rsp_o (vsgen_rsp),
		.sync_o   (vsgen_sync)
	);

	vout_axi4s u_vout (
		.core_clk  (core_clk),
		.rst_i     (rst_i),
		.s_data_i  (fifo_data),
		.s_valid_i (fifo_valid),
		.s_ready_o (fifo_ready),
		.sync_i    (vsgen_sync),
		.sync_o    (vout_sync_o),
		.data_o    (vout_data_o)
	);

endmodule

`default_nettype wire

// File: verilog/vout_axi4s.sv
`timescale 1ns/100ps
`default_nettype none

module vout_axi4s import video_pkg::*; (
	input  wire logic        core_clk,
	input  wire logic        rst_i,

	input  wire pix_stream_t s_data_i,
	input  wire logic        s_valid_i,
	output logic             s_ready_o,

	input  wire video_sync_t sync_i,
	output video_sync_t      sync_o,
	output rgb_t             data_o
);

	logic search_q;

	// ------------------------------
	// frame alignment
	// ------------------------------
	// drop items until a frame start is at the head
	assign s_ready_o = search_q ? !s_data_i.tuser : sync_i.de;

	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			search_q <= 1'b1;
		end else if (sync_i.vsync) begin
			search_q <= 1'b1;
		end else if (search_q && s_valid_i && s_data_i.tuser) begin
			search_q <= 1'b0;
		end
	end

	// ------------------------------
	// output stage
	// ------------------------------
	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			sync_o <= '0;
		end else begin
			sync_o <= sync_i;
		end
	end

	// black while searching or starved
	always_ff @(posedge core_clk) begin
		if (sync_i.de && !search_q && s_valid_i) begin
			data_o <= s_data_i.data;
		end else begin
			data_o <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/vsync_generator.sv
`timescale 1ns/100ps
`default_nettype none

module vsync_generator import video_pkg::*; #(
	parameter int VOUT_X_NUM       = 1280,
	parameter int VOUT_Y_NUM       = 720,
	parameter int INIT_HTOTAL      = 1650,
	parameter int INIT_HSYNC_START = 1390,
	parameter int INIT_HSYNC_END   = 1430,
	parameter int INIT_VTOTAL      = 750,
	parameter int INIT_VSYNC_START = 725,
	parameter int INIT_VSYNC_END   = 730
) (
	input  wire logic    core_clk,
	input  wire logic    rst_i,

	input  wire wb_req_t wb_req_i,
	input  wire logic    stb_i,
	output wb_rsp_t      wb_rsp_o,

	output video_sync_t  sync_o
);

	typedef logic [TIMING_WIDTH-1:0] tcnt_t;

	logic  ctl_en;
	tcnt_t htotal;
	tcnt_t hdisp_end;
	tcnt_t hsync_start;
	tcnt_t hsync_end;
	tcnt_t vtotal;
	tcnt_t vdisp_end;
	tcnt_t vsync_start;
	tcnt_t vsync_end;

	tcnt_t h_cnt;
	tcnt_t v_cnt;

	logic [WB_DAT_WIDTH-1:0] wdat;
	logic [WB_DAT_WIDTH-1:0] rdat;

	// ------------------------------
	// timing registers
	// ------------------------------
	// merge the write over the current value of the addressed register
	assign wdat = wb_merge(rdat, wb_req_i.dat, wb_req_i.sel);

	always_ff @(posedge core_clk) begin
		if (rst_i) begin
			ctl_en      <= 1'b1;
			htotal      <= tcnt_t'(INIT_HTOTAL);
			hdisp_end   <= tcnt_t'(VOUT_X_NUM);
			hsync_start <= tcnt_t'(INIT_HSYNC_START);
			hsync_end   <= tcnt_t'(INIT_HSYNC_END);
			vtotal      <= tcnt_t'(INIT_VTOTAL);
			vdisp_end   <= tcnt_t'(VOUT_Y_NUM);
			vsync_start <= tcnt_t'(INIT_VSYNC_START);
			vsync_end   <= tcnt_t'(INIT_VSYNC_END);
		end else if (stb_i && wb_req_i.we) begin
			case (wb_req_i.adr[7:0])
				VSGEN_CTL:         ctl_en      <= wdat[0];
				VSGEN_HTOTAL:      htotal      <= tcnt_t'(wdat);
				VSGEN_HDISP_END:   hdisp_end   <= tcnt_t'(wdat);
				VSGEN_HSYNC_START: hsync_start <= tcnt_t'(wdat);
				VSGEN_HSYNC_END:   hsync_end   <= tcnt_t'(wdat);
				VSGEN_VTOTAL:      vtotal      <= tcnt_t'(wdat);
				VSGEN_VDISP_END:   vdisp_end   <= tcnt_t'(wdat);
				VSGEN_VSYNC_START: vsync_start <= tcnt_t'(wdat);
				VSGEN_VSYNC_END:   vsync_end   <= tcnt_t'(wdat);
				default: ;
			endcase
		end
	end

	always_comb begin
		case (wb_req_i.adr[7:0])
			VSGEN_CTL:         rdat = WB_DAT_WIDTH'(ctl_en);
			VSGEN_HTOTAL:      rdat = WB_DAT_WIDTH'(htotal);
			VSGEN_HDISP_END:   rdat = WB_DAT_WIDTH'(hdisp_end);
			VSGEN_HSYNC_START: rdat = WB_DAT_WIDTH'(hsync_start);
			VSGEN_HSYNC_END:   rdat = WB_DAT_WIDTH'(hsync_end);
			VSGEN_VTOTAL:      rdat = WB_DAT_WIDTH'(vtotal);
			VSGEN_VDISP_END:   rdat = WB_DAT_WIDTH'(vdisp_end);
			VSGEN_VSYNC_START: rdat = WB_DAT_WIDTH'(vsync_start);
			VSGEN_VSYNC_END:   rdat = WB_DAT_WIDTH'(vsync_end);
			default:           rdat = '0;
		endcase
	end

	assign wb_rsp_o.dat = rdat;
	assign wb_rsp_o.ack = stb_i;

	// ------------------------------
	// counters and syncs
	// ------------------------------
	always_ff @(posedge core_clk) begin
		if (rst_i || !ctl_en) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt >= htotal - 1'b1) begin
			h_cnt <= '0;
			if (v_cnt >= vtotal - 1'b1) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// syncs lag the counter position by one clock
	always_ff @(posedge core_clk) begin
		if (rst_i || !ctl_en) begin
			sync_o <= '0;
		end else begin
			sync_o.de    <= (h_cnt < hdisp_end) && (v_cnt < vdisp_end);
			sync_o.hsync <= (h_cnt >= hsync_start) && (h_cnt < hsync_end);
			sync_o.vsync <= (v_cnt >= vsync_start) && (v_cnt < vsync_end);
		end
	end

	a_h_cnt_range: assert property (@(posedge core_clk) disable iff (rst_i || !ctl_en)
		h_cnt < htotal);

endmodule

`default_nettype wire

// File: verilog/wb_addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module wb_addr_decoder import video_pkg::*; (
	input  wire wb_req_t wb_req_i,

	output logic         bgsrc_stb_o,
	output logic         vsgen_stb_o,
	output logic         gpio_stb_o,

	input  wire wb_rsp_t bgsrc_rsp_i,
	input  wire wb_rsp_t vsgen_rsp_i,
	input  wire wb_rsp_t gpio_rsp_i,

	output wb_rsp_t      wb_rsp_o
);

	logic [7:0] region;

	assign region = wb_req_i.adr[15:8];

	// strobe reaches only the addressed slave
	assign bgsrc_stb_o = wb_req_i.stb && (region == REGION_BGSRC);
	assign vsgen_stb_o = wb_req_i.stb && (region == REGION_VSGEN);
	assign gpio_stb_o  = wb_req_i.stb && (region == REGION_GPIO);

	// ------------------------------
	// response mux
	// ------------------------------
	always_comb begin
		case (region)
			REGION_BGSRC: wb_rsp_o = bgsrc_rsp_i;
			REGION_VSGEN: wb_rsp_o = vsgen_rsp_i;
			REGION_GPIO:  wb_rsp_o = gpio_rsp_i;
			REGION_GID: begin
				wb_rsp_o.dat = GLOBAL_ID;
				wb_rsp_o.ack = wb_req_i.stb;
			end
			default: begin
				// unmapped, ack so the host never hangs
				wb_rsp_o.dat = '0;
				wb_rsp_o.ack = wb_req_i.stb;
			end
		endcase
	end

	// no two slaves see a cycle at once
	always_comb begin
		if (!$isunknown(wb_req_i.adr) && !$isunknown(wb_req_i.stb)) begin
			assert ($onehot0({bgsrc_stb_o, vsgen_stb_o, gpio_stb_o}))
				else $error("more than one slave strobe active");
		end
	end

endmodule

`default_nettype wire
